/* dcd_isa_pkg.sv */
package dcd_isa_pkg;

	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;

	// major opcodes, inst[6:0]
	localparam opcode_t OPC_LUI = 7'b0110111;
	localparam opcode_t OPC_AUIPC = 7'b0010111;
	localparam opcode_t OPC_JAL = 7'b1101111;
	localparam opcode_t OPC_JALR = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD = 7'b0000011;
	localparam opcode_t OPC_STORE = 7'b0100011;
	localparam opcode_t OPC_ARITH_IMM = 7'b0010011;
	localparam opcode_t OPC_ARITH_REG = 7'b0110011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011; // csr access lives here

	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;
	localparam funct3_t F3_BLT = 3'b100;
	localparam funct3_t F3_BGE = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	localparam funct3_t F3_ADD = 3'b000; // add, sub, addi
	localparam funct3_t F3_SLL = 3'b001;
	localparam funct3_t F3_SLT = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR = 3'b100;
	localparam funct3_t F3_SR = 3'b101; // srl and sra split by inst[30]
	localparam funct3_t F3_OR = 3'b110;
	localparam funct3_t F3_AND = 3'b111;

	localparam funct3_t F3_CSRRW = 3'b001;
	localparam funct3_t F3_CSRRS = 3'b010;
	localparam funct3_t F3_CSRRC = 3'b011;
	localparam funct3_t F3_CSRRWI = 3'b101;
	localparam funct3_t F3_CSRRSI = 3'b110;
	localparam funct3_t F3_CSRRCI = 3'b111;

	typedef enum logic [3:0] {
		ADD, SUB, EQU, NEQU,
		SGN_LT, SGN_GE, USGN_LT, USGN_GE,
		XOR, OR, AND,
		SLL, SRL, SRA
	} alu_mode_e;

	// same code as funct3 of the load/store
	typedef enum logic [2:0] {
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010,
		BYTE_U = 3'b100,
		HALF_U = 3'b101
	} ls_type_e;

	typedef enum logic [1:0] {
		LOAD = 2'b00,
		SET = 2'b01,
		CLR = 2'b10
	} csr_upd_e;

	localparam int unsigned LINK_STEP = 4; // no compressed insts, step is fixed

endpackage

/* dcd_core_pkg.sv */
package dcd_core_pkg;

	localparam int XLEN = 32;
	localparam int CSR_AW = 12;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] pc_t;
	typedef logic [CSR_AW-1:0] csr_addr_t;
	typedef logic [XLEN-1:0] imm_t; // already sign extended

	// req/ack controller states
	typedef enum logic [1:0] {
		IDLE,
		DECODE, // operands held, decoders settling
		ACK
	} hs_state_e;

endpackage

/* dcd_if.sv */
`timescale 1ns/10ps

interface dcd_operand_if import dcd_core_pkg::*; ();

	word_t inst;
	pc_t pc;
	word_t rs1_v;
	word_t rs2_v;
	logic prdt_jump;

	modport regs (output inst, pc, rs1_v, rs2_v, prdt_jump);
	modport dec (input inst, pc, rs1_v, rs2_v, prdt_jump);

endinterface

interface dcd_result_if import dcd_isa_pkg::*; import dcd_core_pkg::*; ();

	logic is_b_inst;
	logic is_load_inst;
	logic is_store_inst;
	logic is_csr_rw_inst;
	logic rd_vld;
	alu_mode_e alu_op_mode;
	word_t alu_op1;
	word_t alu_op2;
	ls_type_e ls_type;
	logic ls_addr_aligned;
	csr_addr_t csr_addr;
	csr_upd_e csr_upd_type;
	word_t csr_upd_mask_v;
	pc_t brc_pc_upd;

	modport alu_src (output is_b_inst, is_load_inst, is_store_inst, is_csr_rw_inst,
		rd_vld, alu_op_mode, alu_op1, alu_op2);
	modport lsu_src (output ls_type, ls_addr_aligned, csr_addr, csr_upd_type,
		csr_upd_mask_v);
	modport brc_src (output brc_pc_upd);
	modport sink (input is_b_inst, is_load_inst, is_store_inst, is_csr_rw_inst,
		rd_vld, alu_op_mode, alu_op1, alu_op2, ls_type, ls_addr_aligned,
		csr_addr, csr_upd_type, csr_upd_mask_v, brc_pc_upd);

endinterface

/* dcd_operand_regs.sv */
`timescale 1ns/10ps

module dcd_operand_regs
	import dcd_core_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic capture,
	input word_t inst,
	input pc_t pc,
	input word_t rs1_v,
	input word_t rs2_v,
	input logic prdt_jump,
	dcd_operand_if.regs opnd
);

	// upstream may let go of the bus once ack is seen,
	// so the decoders run from this copy
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			opnd.inst <= '0;
			opnd.pc <= '0;
			opnd.rs1_v <= '0;
			opnd.rs2_v <= '0;
			opnd.prdt_jump <= 1'b0;
		end else if (capture) begin
			opnd.inst <= inst;
			opnd.pc <= pc;
			opnd.rs1_v <= rs1_v; // register file read values
			opnd.rs2_v <= rs2_v;
			opnd.prdt_jump <= prdt_jump;
		end
	end

endmodule

/* dcd_handshake_fsm.sv */
`timescale 1ns/10ps

module dcd_handshake_fsm
	import dcd_core_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic in_req,
	output logic in_ack,
	output logic capture,
	output logic load
);

	hs_state_e state;
	hs_state_e state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (in_req) begin
					state_nxt = DECODE;
				end
			end
			DECODE: state_nxt = ACK; // one cycle for the decoders
			ACK: begin
				if (!in_req) begin
					state_nxt = IDLE; // phase 4, drop ack
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			in_ack <= 1'b0;
		end else begin
			state <= state_nxt;
			in_ack <= (state_nxt == ACK); // ack straight from a flop
		end
	end

	assign capture = (state == IDLE) & in_req;
	assign load = (state == DECODE);

endmodule

/* dcd_alu_decode.sv */
`timescale 1ns/10ps

module dcd_alu_decode
	import dcd_isa_pkg::*;
	import dcd_core_pkg::*;
(
	dcd_operand_if.dec opnd,
	dcd_result_if.alu_src res
);

	opcode_t opc;
	funct3_t funct3;
	logic is_lui;
	logic is_auipc;
	logic is_jal;
	logic is_jalr;
	logic is_b;
	logic is_load;
	logic is_store;
	logic is_csr;
	logic is_arith_imm;
	logic is_arith_reg;
	imm_t arith_imm;
	imm_t ls_ofs;
	imm_t u_imm;

	assign opc = opnd.inst[6:0];
	assign funct3 = opnd.inst[14:12];

	assign is_lui = (opc == OPC_LUI);
	assign is_auipc = (opc == OPC_AUIPC);
	assign is_jal = (opc == OPC_JAL);
	assign is_jalr = (opc == OPC_JALR);
	assign is_b = (opc == OPC_BRANCH);
	assign is_load = (opc == OPC_LOAD);
	assign is_store = (opc == OPC_STORE);
	assign is_csr = (opc == OPC_SYSTEM) & (funct3[1:0] != 2'b00); // not ecall/ebreak/mret
	assign is_arith_imm = (opc == OPC_ARITH_IMM);
	assign is_arith_reg = (opc == OPC_ARITH_REG) & ~opnd.inst[25]; // no M extension

	// shamt field: bit 30 only selects srai
	assign arith_imm = {{20{opnd.inst[31]}},
		opnd.inst[31:20] & {1'b1, ~(funct3 == F3_SR), 10'h3ff}};
	assign ls_ofs = {{20{opnd.inst[31]}}, opnd.inst[31:25],
		is_store ? opnd.inst[11:7] : opnd.inst[24:20]};
	assign u_imm = {opnd.inst[31:12], 12'd0};

	assign res.is_b_inst = is_b;
	assign res.is_load_inst = is_load;
	assign res.is_store_inst = is_store;
	assign res.is_csr_rw_inst = is_csr;
	assign res.rd_vld = is_lui | is_auipc | is_jal | is_jalr | is_load |
		is_arith_imm | is_arith_reg | is_csr;

	always_comb begin
		res.alu_op_mode = ADD; // lui/auipc/jumps/ld/st and anything unknown
		if (is_b) begin
			case (funct3)
				F3_BEQ: res.alu_op_mode = EQU;
				F3_BNE: res.alu_op_mode = NEQU;
				F3_BLT: res.alu_op_mode = SGN_LT;
				F3_BGE: res.alu_op_mode = SGN_GE;
				F3_BLTU: res.alu_op_mode = USGN_LT;
				F3_BGEU: res.alu_op_mode = USGN_GE;
				default: res.alu_op_mode = ADD;
			endcase
		end else if (is_arith_imm | is_arith_reg) begin
			case (funct3)
				F3_ADD: res.alu_op_mode = (is_arith_reg & opnd.inst[30]) ? SUB : ADD;
				F3_SLL: res.alu_op_mode = SLL;
				F3_SLT: res.alu_op_mode = SGN_LT;
				F3_SLTU: res.alu_op_mode = USGN_LT;
				F3_XOR: res.alu_op_mode = XOR;
				F3_SR: res.alu_op_mode = opnd.inst[30] ? SRA : SRL;
				F3_OR: res.alu_op_mode = OR;
				F3_AND: res.alu_op_mode = AND;
				default: res.alu_op_mode = ADD;
			endcase
		end
	end

	always_comb begin
		if (is_auipc | is_jal | is_jalr) begin
			res.alu_op1 = opnd.pc;
		end else if (is_b | is_load | is_store | is_arith_imm | is_arith_reg) begin
			res.alu_op1 = opnd.rs1_v;
		end else begin
			res.alu_op1 = '0; // lui adds to zero
		end
	end

	always_comb begin
		if (is_jal | is_jalr) begin
			res.alu_op2 = word_t'(LINK_STEP); // link address
		end else if (is_lui | is_auipc) begin
			res.alu_op2 = u_imm;
		end else if (is_load | is_store) begin
			res.alu_op2 = ls_ofs;
		end else if (is_arith_imm) begin
			res.alu_op2 = arith_imm;
		end else if (is_b | is_arith_reg) begin
			res.alu_op2 = opnd.rs2_v;
		end else begin
			res.alu_op2 = '0;
		end
	end

endmodule

/* dcd_lsu_csr_decode.sv */
`timescale 1ns/10ps

module dcd_lsu_csr_decode
	import dcd_isa_pkg::*;
	import dcd_core_pkg::*;
(
	dcd_operand_if.dec opnd,
	dcd_result_if.lsu_src res
);

	opcode_t opc;
	funct3_t funct3;
	logic is_ls;
	logic [1:0] ofs_lo;
	logic [1:0] addr_lo;
	word_t uimm;

	assign opc = opnd.inst[6:0];
	assign funct3 = opnd.inst[14:12];
	assign is_ls = (opc == OPC_LOAD) | (opc == OPC_STORE);

	// only the low two address bits matter for alignment
	assign ofs_lo = (opc == OPC_STORE) ? opnd.inst[8:7] : opnd.inst[21:20];
	assign addr_lo = opnd.rs1_v[1:0] + ofs_lo;

	assign res.ls_type = ls_type_e'(funct3);

	always_comb begin
		case (ls_type_e'(funct3))
			BYTE, BYTE_U: res.ls_addr_aligned = is_ls;
			HALF, HALF_U: res.ls_addr_aligned = is_ls & ~addr_lo[0];
			WORD: res.ls_addr_aligned = is_ls & (addr_lo == 2'b00);
			default: res.ls_addr_aligned = 1'b0; // reserved width
		endcase
	end

	assign res.csr_addr = opnd.inst[31:20];
	assign uimm = {27'd0, opnd.inst[19:15]}; // rs1 field as zimm

	always_comb begin
		case (funct3)
			F3_CSRRW: begin
				res.csr_upd_type = LOAD;
				res.csr_upd_mask_v = opnd.rs1_v;
			end
			F3_CSRRS: begin
				res.csr_upd_type = SET;
				res.csr_upd_mask_v = opnd.rs1_v;
			end
			F3_CSRRC: begin
				res.csr_upd_type = CLR;
				res.csr_upd_mask_v = ~opnd.rs1_v; // and-mask for the clear
			end
			F3_CSRRWI: begin
				res.csr_upd_type = LOAD;
				res.csr_upd_mask_v = uimm;
			end
			F3_CSRRSI: begin
				res.csr_upd_type = SET;
				res.csr_upd_mask_v = uimm;
			end
			F3_CSRRCI: begin
				res.csr_upd_type = CLR;
				res.csr_upd_mask_v = ~uimm;
			end
			default: begin
				res.csr_upd_type = LOAD;
				res.csr_upd_mask_v = '0;
			end
		endcase
	end

endmodule

/* dcd_brc_pc.sv */
`timescale 1ns/10ps

module dcd_brc_pc
	import dcd_isa_pkg::*;
	import dcd_core_pkg::*;
(
	dcd_operand_if.dec opnd,
	dcd_result_if.brc_src res
);

	opcode_t opc;
	imm_t b_ofs;
	imm_t j_ofs;
	imm_t addend;

	assign opc = opnd.inst[6:0];

	assign b_ofs = {{20{opnd.inst[31]}}, opnd.inst[7], opnd.inst[30:25],
		opnd.inst[11:8], 1'b0};
	assign j_ofs = {{12{opnd.inst[31]}}, opnd.inst[19:12], opnd.inst[20],
		opnd.inst[30:21], 1'b0};

	// predicted taken recovers to the fall-through, else to the target
	always_comb begin
		if (opnd.prdt_jump) begin
			addend = imm_t'(LINK_STEP);
		end else if (opc == OPC_BRANCH) begin
			addend = b_ofs;
		end else if (opc == OPC_JAL) begin
			addend = j_ofs;
		end else begin
			addend = imm_t'(LINK_STEP);
		end
	end

	assign res.brc_pc_upd = opnd.pc + addend;

endmodule

/* dcd_result_regs.sv */
`timescale 1ns/10ps

module dcd_result_regs
	import dcd_isa_pkg::*;
	import dcd_core_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic load,
	dcd_result_if.sink res,
	output logic is_b_inst,
	output logic is_load_inst,
	output logic is_store_inst,
	output logic is_csr_rw_inst,
	output logic rd_vld,
	output alu_mode_e alu_op_mode,
	output word_t alu_op1,
	output word_t alu_op2,
	output ls_type_e ls_type,
	output logic ls_addr_aligned,
	output csr_addr_t csr_addr,
	output csr_upd_e csr_upd_type,
	output word_t csr_upd_mask_v,
	output pc_t brc_pc_upd
);

	// frozen from load until the next transaction
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			is_b_inst <= 1'b0;
			is_load_inst <= 1'b0;
			is_store_inst <= 1'b0;
			is_csr_rw_inst <= 1'b0;
			rd_vld <= 1'b0;
			alu_op_mode <= ADD; // code 0
			alu_op1 <= '0;
			alu_op2 <= '0;
			ls_type <= BYTE;
			ls_addr_aligned <= 1'b0;
			csr_addr <= '0;
			csr_upd_type <= LOAD;
			csr_upd_mask_v <= '0;
			brc_pc_upd <= '0;
		end else if (load) begin
			is_b_inst <= res.is_b_inst;
			is_load_inst <= res.is_load_inst;
			is_store_inst <= res.is_store_inst;
			is_csr_rw_inst <= res.is_csr_rw_inst;
			rd_vld <= res.rd_vld;
			alu_op_mode <= res.alu_op_mode;
			alu_op1 <= res.alu_op1;
			alu_op2 <= res.alu_op2;
			ls_type <= res.ls_type;
			ls_addr_aligned <= res.ls_addr_aligned;
			csr_addr <= res.csr_addr;
			csr_upd_type <= res.csr_upd_type;
			csr_upd_mask_v <= res.csr_upd_mask_v;
			brc_pc_upd <= res.brc_pc_upd;
		end
	end

endmodule

/* dcd_top.sv */
`timescale 1ns/10ps

module dcd_top
	import dcd_isa_pkg::*;
	import dcd_core_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic in_req,
	output logic in_ack,
	input word_t inst,
	input pc_t pc,
	input word_t rs1_v,
	input word_t rs2_v,
	input logic prdt_jump,
	output logic is_b_inst,
	output logic is_load_inst,
	output logic is_store_inst,
	output logic is_csr_rw_inst,
	output logic rd_vld,
	output alu_mode_e alu_op_mode,
	output word_t alu_op1,
	output word_t alu_op2,
	output ls_type_e ls_type,
	output logic ls_addr_aligned,
	output csr_addr_t csr_addr,
	output csr_upd_e csr_upd_type,
	output word_t csr_upd_mask_v,
	output pc_t brc_pc_upd
);

	logic capture; // operand load, IDLE with req
	logic load; // result load, one cycle later

	dcd_operand_if opnd_if ();
	dcd_result_if res_if ();

	dcd_handshake_fsm u_hs_fsm (
		.clk (clk),
		.arst_n (arst_n),
		.in_req (in_req),
		.in_ack (in_ack),
		.capture (capture),
		.load (load)
	);

	dcd_operand_regs u_opnd_regs (
		.clk (clk),
		.arst_n (arst_n),
		.capture (capture),
		.inst (inst),
		.pc (pc),
		.rs1_v (rs1_v),
		.rs2_v (rs2_v),
		.prdt_jump (prdt_jump),
		.opnd (opnd_if.regs)
	);

	dcd_alu_decode u_alu_dcd (
		.opnd (opnd_if.dec),
		.res (res_if.alu_src)
	);

	dcd_lsu_csr_decode u_lsu_csr_dcd (
		.opnd (opnd_if.dec),
		.res (res_if.lsu_src)
	);

	dcd_brc_pc u_brc_pc (
		.opnd (opnd_if.dec),
		.res (res_if.brc_src)
	);

	dcd_result_regs u_res_regs (
		.clk (clk),
		.arst_n (arst_n),
		.load (load),
		.res (res_if.sink),
		.is_b_inst (is_b_inst),
		.is_load_inst (is_load_inst),
		.is_store_inst (is_store_inst),
		.is_csr_rw_inst (is_csr_rw_inst),
		.rd_vld (rd_vld),
		.alu_op_mode (alu_op_mode),
		.alu_op1 (alu_op1),
		.alu_op2 (alu_op2),
		.ls_type (ls_type),
		.ls_addr_aligned (ls_addr_aligned),
		.csr_addr (csr_addr),
		.csr_upd_type (csr_upd_type),
		.csr_upd_mask_v (csr_upd_mask_v),
		.brc_pc_upd (brc_pc_upd)
	);

endmodule

/* dcd_props.sv */
`timescale 1ns/10ps

module dcd_props (
	input logic clk,
	input logic arst_n,
	input logic in_req,
	input logic in_ack,
	input logic [3:0] alu_op_mode,
	input logic [31:0] alu_op1,
	input logic [31:0] alu_op2,
	input logic [31:0] csr_upd_mask_v,
	input logic [31:0] brc_pc_upd
);

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(in_ack) |-> $past(in_req))
		else $error("in_ack rose without in_req");

	results_held: assert property (@(posedge clk) disable iff (!arst_n)
		(in_ack && $past(in_ack)) |->
		$stable({alu_op_mode, alu_op1, alu_op2, csr_upd_mask_v, brc_pc_upd}))
		else $error("decode outputs changed while in_ack was high");

	ack_falls_after_req: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(in_ack) |-> !$past(in_req))
		else $error("in_ack fell while in_req was still high");

endmodule

bind dcd_top dcd_props u_props (
	.clk (clk),
	.arst_n (arst_n),
	.in_req (in_req),
	.in_ack (in_ack),
	.alu_op_mode (alu_op_mode),
	.alu_op1 (alu_op1),
	.alu_op2 (alu_op2),
	.csr_upd_mask_v (csr_upd_mask_v),
	.brc_pc_upd (brc_pc_upd)
);

/* tb_dcd.sv */
`timescale 1ns/10ps

module tb_dcd
	import dcd_isa_pkg::*;
	import dcd_core_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int RST_CYC = 16;
	localparam int N_TXN = 46; // transactions over all tests
	localparam int WDOG_CYC = N_TXN * 10 + RST_CYC + 200;

	logic clk;
	logic arst_n;
	logic in_req;
	logic in_ack;
	word_t inst;
	pc_t pc;
	word_t rs1_v;
	word_t rs2_v;
	logic prdt_jump;
	logic is_b_inst;
	logic is_load_inst;
	logic is_store_inst;
	logic is_csr_rw_inst;
	logic rd_vld;
	alu_mode_e alu_op_mode;
	word_t alu_op1;
	word_t alu_op2;
	ls_type_e ls_type;
	logic ls_addr_aligned;
	csr_addr_t csr_addr;
	csr_upd_e csr_upd_type;
	word_t csr_upd_mask_v;
	pc_t brc_pc_upd;

	integer seed;
	int n_errors;
	int n_checks;
	int n_tests;

	dcd_top DUT (
		.clk (clk),
		.arst_n (arst_n),
		.in_req (in_req),
		.in_ack (in_ack),
		.inst (inst),
		.pc (pc),
		.rs1_v (rs1_v),
		.rs2_v (rs2_v),
		.prdt_jump (prdt_jump),
		.is_b_inst (is_b_inst),
		.is_load_inst (is_load_inst),
		.is_store_inst (is_store_inst),
		.is_csr_rw_inst (is_csr_rw_inst),
		.rd_vld (rd_vld),
		.alu_op_mode (alu_op_mode),
		.alu_op1 (alu_op1),
		.alu_op2 (alu_op2),
		.ls_type (ls_type),
		.ls_addr_aligned (ls_addr_aligned),
		.csr_addr (csr_addr),
		.csr_upd_type (csr_upd_type),
		.csr_upd_mask_v (csr_upd_mask_v),
		.brc_pc_upd (brc_pc_upd)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// instruction word builders, one per RV32I format
	function automatic word_t r_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input funct3_t f3, input logic [4:0] rd, input opcode_t opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic word_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
		input funct3_t f3, input logic [4:0] rd, input opcode_t opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t s_word(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input funct3_t f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t b_word(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input funct3_t f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic word_t u_word(input logic [19:0] imm, input logic [4:0] rd,
		input opcode_t opc);
		return {imm, rd, opc};
	endfunction

	function automatic word_t j_word(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
			n_errors++;
		end
	endtask

	task automatic flag_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		n_errors++;
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		if (n_errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, n_errors - errs_before);
		end
	endtask

	// one four-phase transaction, entered and left 1 ns after a rising edge
	task automatic do_txn(input word_t i_inst, input pc_t i_pc, input word_t a,
		input word_t b, input logic pj, input int hold);
		int waited;
		inst = i_inst;
		pc = i_pc;
		rs1_v = a;
		rs2_v = b;
		prdt_jump = pj;
		in_req = 1'b1;
		@(posedge clk);
		#1;
		if (in_ack) flag_error("in_ack rose one edge after in_req");
		@(posedge clk);
		#1;
		if (!in_ack) flag_error("in_ack was not high two edges after in_req");
		repeat (hold) begin
			@(posedge clk);
			#1;
			if (!in_ack) flag_error("in_ack dropped while in_req was held high");
		end
		in_req = 1'b0;
		inst = $random(seed); // bus is free again, outputs must not follow
		rs1_v = $random(seed);
		rs2_v = $random(seed);
		waited = 0;
		while (in_ack && waited < 4) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (in_ack) flag_error("in_ack did not fall after in_req dropped");
	endtask

	task automatic verify_alu(input alu_mode_e mode, input word_t op1, input word_t op2,
		input logic rdv);
		check("alu_op_mode", 32'(alu_op_mode), 32'(mode));
		check("alu_op1", alu_op1, op1);
		check("alu_op2", alu_op2, op2);
		check("rd_vld", 32'(rd_vld), 32'(rdv));
	endtask

	task automatic reset_and_handshake();
		int e0;
		word_t a;
		e0 = n_errors;
		check("in_ack", 32'(in_ack), 32'd0);
		check("is_b_inst", 32'(is_b_inst), 32'd0);
		check("is_load_inst", 32'(is_load_inst), 32'd0);
		check("is_store_inst", 32'(is_store_inst), 32'd0);
		check("is_csr_rw_inst", 32'(is_csr_rw_inst), 32'd0);
		check("rd_vld", 32'(rd_vld), 32'd0);
		check("alu_op_mode", 32'(alu_op_mode), 32'd0);
		check("alu_op1", alu_op1, 32'd0);
		check("alu_op2", alu_op2, 32'd0);
		check("ls_type", 32'(ls_type), 32'd0);
		check("ls_addr_aligned", 32'(ls_addr_aligned), 32'd0);
		check("csr_addr", 32'(csr_addr), 32'd0);
		check("csr_upd_type", 32'(csr_upd_type), 32'd0);
		check("csr_upd_mask_v", csr_upd_mask_v, 32'd0);
		check("brc_pc_upd", brc_pc_upd, 32'd0);
		a = $random(seed);
		do_txn(i_word(12'h7ff, 5'd1, F3_ADD, 5'd2, OPC_ARITH_IMM), 32'h0000_0200, a,
			32'd0, 1'b0, 4); // addi, req held 4 extra cycles
		verify_alu(ADD, a, 32'h0000_07ff, 1'b1);
		// fence opcode, outside the decoded set
		do_txn(i_word(12'h0ff, 5'd0, 3'b000, 5'd0, 7'b0001111), 32'h0000_0300, a, a,
			1'b0, 0);
		verify_alu(ADD, 32'd0, 32'd0, 1'b0);
		check("is_b_inst", 32'(is_b_inst), 32'd0);
		check("is_load_inst", 32'(is_load_inst), 32'd0);
		check("is_store_inst", 32'(is_store_inst), 32'd0);
		check("is_csr_rw_inst", 32'(is_csr_rw_inst), 32'd0);
		check("ls_addr_aligned", 32'(ls_addr_aligned), 32'd0);
		check("brc_pc_upd", brc_pc_upd, 32'h0000_0304);
		report_test("reset_and_handshake", e0);
	endtask

	task automatic arith_case(input word_t ins, input alu_mode_e mode, input logic use_imm,
		input word_t imm);
		word_t a;
		word_t b;
		a = $random(seed);
		b = $random(seed);
		do_txn(ins, 32'h0000_0400, a, b, 1'b0, 0);
		verify_alu(mode, a, use_imm ? imm : b, 1'b1);
	endtask

	task automatic arith_ops();
		int e0;
		e0 = n_errors;
		arith_case(r_word(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3, OPC_ARITH_REG), ADD, 1'b0, 32'd0);
		arith_case(r_word(7'h20, 5'd2, 5'd1, F3_ADD, 5'd3, OPC_ARITH_REG), SUB, 1'b0, 32'd0);
		arith_case(r_word(7'h00, 5'd4, 5'd5, F3_SLT, 5'd6, OPC_ARITH_REG), SGN_LT, 1'b0,
			32'd0);
		arith_case(i_word(12'hffb, 5'd7, F3_SLTU, 5'd8, OPC_ARITH_IMM), USGN_LT, 1'b1,
			32'hffff_fffb);
		arith_case(i_word(12'h8a3, 5'd9, F3_XOR, 5'd10, OPC_ARITH_IMM), XOR, 1'b1,
			32'hffff_f8a3);
		arith_case(i_word(12'h007, 5'd11, F3_SLL, 5'd12, OPC_ARITH_IMM), SLL, 1'b1, 32'd7);
		arith_case(i_word(12'h40d, 5'd13, F3_SR, 5'd14, OPC_ARITH_IMM), SRA, 1'b1, 32'd13);
		arith_case(r_word(7'h00, 5'd15, 5'd16, F3_AND, 5'd17, OPC_ARITH_REG), AND, 1'b0,
			32'd0);
		report_test("arith_ops", e0);
	endtask

	task automatic upper_and_jumps();
		int e0;
		pc_t pc_v;
		word_t a;
		e0 = n_errors;
		pc_v = 32'h0000_1a40;
		a = $random(seed);
		do_txn(u_word(20'habcde, 5'd5, OPC_LUI), pc_v, a, a, 1'b0, 0);
		verify_alu(ADD, 32'd0, 32'habcd_e000, 1'b1);
		do_txn(u_word(20'h12345, 5'd6, OPC_AUIPC), pc_v, a, a, 1'b0, 0);
		verify_alu(ADD, pc_v, 32'h1234_5000, 1'b1);
		do_txn(j_word(21'h000100, 5'd1), pc_v, a, a, 1'b0, 0);
		verify_alu(ADD, pc_v, 32'd4, 1'b1);
		do_txn(i_word(12'h010, 5'd7, 3'b000, 5'd1, OPC_JALR), pc_v, a, a, 1'b0, 0);
		verify_alu(ADD, pc_v, 32'd4, 1'b1);
		report_test("upper_and_jumps", e0);
	endtask

	task automatic ls_case(input logic st, input funct3_t f3, input logic [11:0] ofs,
		input logic [1:0] lo);
		word_t a;
		word_t b;
		word_t ofs_x;
		word_t addr;
		word_t ins;
		logic exp_al;
		a = ($random(seed) & 32'hffff_fffc) | {30'd0, lo};
		b = $random(seed);
		ofs_x = {{20{ofs[11]}}, ofs};
		addr = a + ofs_x;
		case (f3)
			3'b000, 3'b100: exp_al = 1'b1;
			3'b001, 3'b101: exp_al = ~addr[0];
			default: exp_al = (addr[1:0] == 2'b00);
		endcase
		ins = st ? s_word(ofs, 5'd9, 5'd10, f3) : i_word(ofs, 5'd10, f3, 5'd11, OPC_LOAD);
		do_txn(ins, 32'h0000_0600, a, b, 1'b0, 0);
		verify_alu(ADD, a, ofs_x, !st);
		check("ls_type", 32'(ls_type), 32'(f3));
		check("ls_addr_aligned", 32'(ls_addr_aligned), 32'(exp_al));
		check("is_load_inst", 32'(is_load_inst), 32'(!st));
		check("is_store_inst", 32'(is_store_inst), 32'(st));
	endtask

	task automatic load_store();
		int e0;
		e0 = n_errors;
		ls_case(1'b0, 3'b000, 12'hffd, 2'b10);
		ls_case(1'b0, 3'b001, 12'h002, 2'b01); // half, odd address
		ls_case(1'b0, 3'b001, 12'h006, 2'b10);
		ls_case(1'b0, 3'b010, 12'h004, 2'b00);
		ls_case(1'b0, 3'b010, 12'h002, 2'b00); // word, off by two
		ls_case(1'b0, 3'b100, 12'h7ff, 2'b11);
		ls_case(1'b0, 3'b101, 12'hfff, 2'b01);
		ls_case(1'b1, 3'b000, 12'h123, 2'b01);
		ls_case(1'b1, 3'b001, 12'h801, 2'b00);
		ls_case(1'b1, 3'b010, 12'hff8, 2'b00);
		ls_case(1'b1, 3'b010, 12'h005, 2'b11); // low bits wrap to 00
		ls_case(1'b1, 3'b010, 12'h001, 2'b00);
		report_test("load_store", e0);
	endtask

	task automatic csr_case(input funct3_t f3, input logic [11:0] addr, input logic [4:0] field,
		input csr_upd_e typ, input logic imm_form, input logic invert);
		word_t a;
		word_t m;
		a = $random(seed);
		m = imm_form ? {27'd0, field} : a;
		if (invert) m = ~m;
		do_txn(i_word(addr, field, f3, 5'd12, OPC_SYSTEM), 32'h0000_0800, a, 32'd0, 1'b0, 0);
		check("is_csr_rw_inst", 32'(is_csr_rw_inst), 32'd1);
		check("rd_vld", 32'(rd_vld), 32'd1);
		check("csr_addr", 32'(csr_addr), {20'd0, addr});
		check("csr_upd_type", 32'(csr_upd_type), 32'(typ));
		check("csr_upd_mask_v", csr_upd_mask_v, m);
	endtask

	task automatic csr_access();
		int e0;
		e0 = n_errors;
		csr_case(F3_CSRRW, 12'h300, 5'd3, LOAD, 1'b0, 1'b0);
		csr_case(F3_CSRRS, 12'h341, 5'd4, SET, 1'b0, 1'b0);
		csr_case(F3_CSRRC, 12'h7c0, 5'd5, CLR, 1'b0, 1'b1);
		csr_case(F3_CSRRWI, 12'h305, 5'h15, LOAD, 1'b1, 1'b0);
		csr_case(F3_CSRRSI, 12'hb00, 5'h1f, SET, 1'b1, 1'b0);
		csr_case(F3_CSRRCI, 12'hf14, 5'h03, CLR, 1'b1, 1'b1);
		report_test("csr_access", e0);
	endtask

	// same branch twice, first not predicted, then predicted taken
	task automatic branch_pair(input funct3_t f3, input alu_mode_e mode, input logic [12:0] ofs);
		word_t a;
		word_t b;
		pc_t pc_v;
		pc_v = 32'h0000_8000;
		for (int pj = 0; pj < 2; pj++) begin
			a = $random(seed);
			b = $random(seed);
			do_txn(b_word(ofs, 5'd4, 5'd3, f3), pc_v, a, b, pj[0], 0);
			verify_alu(mode, a, b, 1'b0);
			check("is_b_inst", 32'(is_b_inst), 32'd1);
			check("brc_pc_upd", brc_pc_upd,
				pj[0] ? pc_v + 32'd4 : pc_v + {{19{ofs[12]}}, ofs});
		end
	endtask

	task automatic jal_target(input logic [20:0] ofs);
		pc_t pc_v;
		pc_v = 32'h0010_0000;
		do_txn(j_word(ofs, 5'd1), pc_v, 32'd0, 32'd0, 1'b0, 0);
		verify_alu(ADD, pc_v, 32'd4, 1'b1);
		check("brc_pc_upd", brc_pc_upd, pc_v + {{11{ofs[20]}}, ofs});
	endtask

	task automatic branches();
		int e0;
		e0 = n_errors;
		branch_pair(F3_BEQ, EQU, 13'h0100);
		branch_pair(F3_BNE, NEQU, 13'h1fe0);
		branch_pair(F3_BLT, SGN_LT, 13'h0ffe);
		branch_pair(F3_BGE, SGN_GE, 13'h1000); // most negative offset
		branch_pair(F3_BLTU, USGN_LT, 13'h0008);
		branch_pair(F3_BGEU, USGN_GE, 13'h1f2a);
		jal_target(21'h1edcbc);
		jal_target(21'h00ff2e);
		report_test("branches", e0);
	endtask

	initial begin
		#(WDOG_CYC * CLK_PERIOD);
		$display("timeout: tests still running after %0d cycles", WDOG_CYC);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		seed = 32'h5626a21a;
		n_errors = 0;
		n_checks = 0;
		n_tests = 0;
		arst_n = 1'b0;
		in_req = 1'b0;
		inst = '0;
		pc = '0;
		rs1_v = '0;
		rs2_v = '0;
		prdt_jump = 1'b0;
		repeat (RST_CYC) @(posedge clk);
		#1;
		arst_n = 1'b1;
		reset_and_handshake();
		arith_ops();
		upper_and_jumps();
		load_store();
		csr_access();
		branches();
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* verilog.f */
dcd_isa_pkg.sv
dcd_core_pkg.sv
dcd_if.sv
dcd_operand_regs.sv
dcd_handshake_fsm.sv
dcd_alu_decode.sv
dcd_lsu_csr_decode.sv
dcd_brc_pc.sv
dcd_result_regs.sv
dcd_top.sv
dcd_props.sv
tb_dcd.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_dcd
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
